// File: all.f
+incdir+rtl
rtl/vrf_inst_pkg.sv
rtl/vrf_seq_pkg.sv
rtl/vrf_addr_counter.sv
rtl/byte_enable_gen.sv
rtl/lane_valid_mask.sv
rtl/vrf_seq_fsm.sv
rtl/vrf_access_ctrl.sv
bench/vrf_access_ctrl_checker.sv
bench/vrf_access_ctrl_tb.sv

// File: bench/vrf_access_ctrl_checker.sv
// Strobe rule assertions for the VRF access controller
// Bound into the top level, looks at its ports and the sequencer state

`timescale 1ns/1ps

`include "vrf_ctrl_settings.svh"

module vrf_access_ctrl_checker (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          ready_o,
    input  logic                          store_data_valid_o,
    input  logic                          ready_for_load_o,
    input  logic                          vmrf_wen_o,
    input  logic [`VLANE_NUM-1:0][3:0]    vrf_bwen_o,
    input  vrf_seq_pkg::seq_state_e       state_i
);

    // No byte writes between instructions
    bwen_idle_a: assert property (@(posedge clk_i) disable iff (!rst_i)
        ready_o |-> (vrf_bwen_o == '0))
        else $error("Byte write enable active while ready_o is high");

    // Store and load strobes are exclusive
    store_load_a: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(store_data_valid_o && ready_for_load_o))
        else $error("store_data_valid_o and ready_for_load_o high together");

    mask_idle_a: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_i == vrf_seq_pkg::SEQ_IDLE) |-> !vmrf_wen_o)
        else $error("Mask register write while the sequencer is idle");

endmodule

bind vrf_access_ctrl vrf_access_ctrl_checker i_checker (
    .clk_i(clk_i), .rst_i(rst_i), .ready_o(ready_o),
    .store_data_valid_o(store_data_valid_o), .ready_for_load_o(ready_for_load_o),
    .vmrf_wen_o(vmrf_wen_o), .vrf_bwen_o(vrf_bwen_o), .state_i(i_seq.state_q)
);

// File: bench/vrf_access_ctrl_tb.sv
// Testbench for the VRF access controller
// Directed tests for normal, store and load instructions

`timescale 1ns/1ps

`include "vrf_ctrl_settings.svh"

module vrf_access_ctrl_tb;

    localparam int AW           = `VRF_ADDR_W;
    localparam int VLW          = `VL_W;
    localparam int VPLW         = `VPL_W;
    localparam int CLK_PERIOD   = 8;
    localparam int SAMPLE_DLY   = 2;       // After the falling edge drive
    localparam int RESET_CYCLES = 16;
    // Longest test is the load with 10 fires and gaps up to 3 cycles
    localparam int TEST_MAX_CYCLES = 48;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + 6 * TEST_MAX_CYCLES + 32;
    localparam logic [31:0] SEED   = 32'hb11341f7;

    logic                                   clk_i;
    logic                                   rst_i;
    logic                                   start_i;
    vrf_inst_pkg::inst_kind_e               inst_kind_i;
    logic [VLW-1:0]                         vl_i;
    vrf_inst_pkg::elem_width_e              vsew_i;
    vrf_inst_pkg::elem_width_e              wdata_width_i;
    logic [VPLW-1:0]                        inst_delay_i;
    logic                                   vector_mask_i;
    logic [AW-1:0]                          vrf_start_waddr_i;
    logic [`RD_PORT_NUM-1:0][AW-1:0]        vrf_start_raddr_i;
    logic                                   load_valid_i;
    logic                                   load_last_i;
    logic [`VLANE_NUM-1:0][3:0]             load_bwen_i;
    logic                                   ready_o;
    logic                                   ready_for_load_o;
    logic                                   store_data_valid_o;
    logic [`RD_PORT_NUM-1:0][AW-1:0]        vrf_raddr_o;
    logic [`VLANE_NUM-1:0][AW-1:0]          vrf_waddr_o;
    logic [`VLANE_NUM-1:0][3:0]             vrf_bwen_o;
    logic [`VLANE_NUM-1:0]                  read_data_valid_o;
    logic [VPLW-1:0]                        vmrf_addr_o;
    logic                                   vmrf_wen_o;

    int          cycle_cnt = 0;

    vrf_access_ctrl i_dut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            report_failure("Timeout: the DUT did not finish the tests in time");
        end
    end

    ////////////////////////////////////////
    // Failure reporting and compares
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_addr(input string name, input logic [AW-1:0] exp,
                              input logic [AW-1:0] act);
        if (exp !== act) begin
            report_failure($sformatf("** Error at %0t: %s expected 0x%h, got 0x%h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_bwen(input string name, input logic [`VLANE_NUM-1:0][3:0] exp,
                              input logic [`VLANE_NUM-1:0][3:0] act);
        if (exp !== act) begin
            report_failure($sformatf("** Error at %0t: %s expected 0x%h, got 0x%h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_mask(input string name, input logic [`VLANE_NUM-1:0] exp,
                              input logic [`VLANE_NUM-1:0] act);
        if (exp !== act) begin
            report_failure($sformatf("** Error at %0t: %s expected %b, got %b",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_failure($sformatf("** Error at %0t: %s expected %b, got %b",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_waddr(input logic [AW-1:0] exp);
        for (int l = 0; l < `VLANE_NUM; l++) begin
            check_addr($sformatf("vrf_waddr_o[%0d]", l), exp, vrf_waddr_o[l]);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers
    function automatic int width_bytes(input vrf_inst_pkg::elem_width_e w);
        case (w)
            vrf_inst_pkg::EW_BYTE: return 1;
            vrf_inst_pkg::EW_HALF: return 2;
            vrf_inst_pkg::EW_WORD: return 4;
            default:               return 0;
        endcase
    endfunction

    // Byte lanes of write number j
    function automatic logic [3:0] bwen_pattern(input vrf_inst_pkg::elem_width_e w,
                                                input int j);
        case (w)
            vrf_inst_pkg::EW_BYTE: return 4'(4'b0001 << (j % 4));
            vrf_inst_pkg::EW_HALF: return ((j % 2) == 0) ? 4'b0011 : 4'b1100;
            vrf_inst_pkg::EW_WORD: return 4'b1111;
            default:               return 4'b0000;
        endcase
    endfunction

    task automatic next_cycle();
        @(negedge clk_i);
        #SAMPLE_DLY;
    endtask

    // Present one instruction and return in the first cycle after acceptance
    task automatic issue(input vrf_inst_pkg::inst_kind_e kind, input logic [VLW-1:0] vl,
                         input vrf_inst_pkg::elem_width_e vsew,
                         input vrf_inst_pkg::elem_width_e wdw, input int delay,
                         input logic mask, input logic [AW-1:0] waddr,
                         input logic [`RD_PORT_NUM-1:0][AW-1:0] raddr);
        @(negedge clk_i);
        start_i           = 1'b1;
        inst_kind_i       = kind;
        vl_i              = vl;
        vsew_i            = vsew;
        wdata_width_i     = wdw;
        inst_delay_i      = VPLW'(delay);
        vector_mask_i     = mask;
        vrf_start_waddr_i = waddr;
        vrf_start_raddr_i = raddr;
        #SAMPLE_DLY;
        check_bit("ready_o", 1'b1, ready_o);
        @(negedge clk_i);
        start_i = 1'b0;
        #SAMPLE_DLY;
        check_bit("ready_o", 1'b0, ready_o);
    endtask

    ////////////////////////////////////////
    // Normal instruction checked cycle by cycle
    task automatic run_normal(input logic [VLW-1:0] vl, input vrf_inst_pkg::elem_width_e vsew,
                              input vrf_inst_pkg::elem_width_e wdw, input int delay,
                              input logic mask);
        int limit;
        int k;
        int n_rd;
        int n_wr;
        int lanes;
        logic wr;
        logic [AW-1:0] waddr0;
        logic [`RD_PORT_NUM-1:0][AW-1:0] raddr0;
        logic [`VLANE_NUM-1:0] vmask;
        limit  = (int'(vl) + `VLANE_NUM - 1) / `VLANE_NUM;
        waddr0 = AW'($urandom);
        for (int p = 0; p < `RD_PORT_NUM; p++) begin
            raddr0[p] = AW'($urandom);
        end
        issue(vrf_inst_pkg::INST_NORMAL, vl, vsew, wdw, delay, mask, waddr0, raddr0);
        k = 0;
        while (!ready_o) begin
            wr    = (k >= delay) && (k < delay + limit);
            n_rd  = (k < limit) ? k : limit;
            n_wr  = (k < delay) ? 0 : ((k - delay < limit) ? k - delay : limit);
            vmask = '0;
            if (k >= 1 && k <= limit) begin     // Row k-1 shows one cycle late
                lanes = int'(vl) - `VLANE_NUM * (k - 1);
                for (int l = 0; l < `VLANE_NUM && l < lanes; l++) vmask[l] = 1'b1;
            end
            for (int p = 0; p < `RD_PORT_NUM; p++) begin
                check_addr($sformatf("vrf_raddr_o[%0d]", p),
                           raddr0[p] + AW'((n_rd * width_bytes(vsew)) / 4), vrf_raddr_o[p]);
            end
            check_mask("read_data_valid_o", vmask, read_data_valid_o);
            check_bwen("vrf_bwen_o", wr ? {`VLANE_NUM{bwen_pattern(wdw, n_wr)}} : '0,
                       vrf_bwen_o);
            check_waddr(waddr0 + AW'((n_wr * width_bytes(wdw)) / 4));
            check_addr("vmrf_addr_o", AW'(n_wr), AW'(vmrf_addr_o));
            check_bit("vmrf_wen_o", wr & mask, vmrf_wen_o);
            check_bit("store_data_valid_o", 1'b0, store_data_valid_o);
            next_cycle();
            k++;
        end
        if (k != delay + limit) begin
            report_failure($sformatf("ready_o rose %0d cycles after a normal start, expected %0d",
                                     k, delay + limit));
        end
        check_addr("vmrf_addr_o", AW'(limit), AW'(vmrf_addr_o));
        check_bwen("vrf_bwen_o", '0, vrf_bwen_o);
    endtask

    ////////////////////////////////////////
    // Tests
    task automatic reset_test();
        next_cycle();
        check_bit("ready_o", 1'b1, ready_o);
        check_bit("ready_for_load_o", 1'b0, ready_for_load_o);
        check_bit("store_data_valid_o", 1'b0, store_data_valid_o);
        check_bit("vmrf_wen_o", 1'b0, vmrf_wen_o);
        check_bwen("vrf_bwen_o", '0, vrf_bwen_o);
        check_mask("read_data_valid_o", '0, read_data_valid_o);
        check_waddr('0);
        for (int p = 0; p < `RD_PORT_NUM; p++) begin
            check_addr($sformatf("vrf_raddr_o[%0d]", p), '0, vrf_raddr_o[p]);
        end
        check_addr("vmrf_addr_o", '0, AW'(vmrf_addr_o));
        issue(vrf_inst_pkg::INST_STORE, VLW'(8), vrf_inst_pkg::EW_WORD,
              vrf_inst_pkg::EW_NONE, 0, 1'b0, '0, '0);
        while (!ready_o) next_cycle();
    endtask

    task automatic byte_write_test();
        run_normal(VLW'($urandom_range(17, 64)), vrf_inst_pkg::EW_BYTE,
                   vrf_inst_pkg::EW_BYTE, int'($urandom_range(1, 8)), 1'b1);
    endtask

    task automatic partial_row_test();
        int rows;
        int rem;
        rows = int'($urandom_range(1, 5));
        rem  = int'($urandom_range(1, 7));      // Never a multiple of the lane count
        run_normal(VLW'(8 * rows + rem), vrf_inst_pkg::EW_WORD, vrf_inst_pkg::EW_WORD, 3, 1'b1);
    endtask

    task automatic store_test();
        int limit;
        int k;
        logic [VLW-1:0] vl;
        vl    = VLW'($urandom_range(1, 64));
        limit = (int'(vl) + `VLANE_NUM - 1) / `VLANE_NUM;
        issue(vrf_inst_pkg::INST_STORE, vl, vrf_inst_pkg::EW_WORD, vrf_inst_pkg::EW_NONE,
              0, 1'b0, '0, '0);
        k = 0;
        while (!ready_o) begin
            check_bit("store_data_valid_o", k < limit, store_data_valid_o);
            check_bit("ready_for_load_o", 1'b0, ready_for_load_o);
            next_cycle();
            k++;
        end
        if (k != limit) begin
            report_failure($sformatf("ready_o rose %0d cycles after a store start, expected %0d",
                                     k, limit));
        end
        check_bit("store_data_valid_o", 1'b0, store_data_valid_o);
    endtask

    task automatic load_test();
        int n_fire;
        int fires;
        int gap;
        logic [AW-1:0] waddr0;
        logic [`VLANE_NUM-1:0][3:0] bwen_v;
        n_fire = int'($urandom_range(4, 10));
        waddr0 = AW'($urandom);
        issue(vrf_inst_pkg::INST_LOAD, VLW'(8 * n_fire), vrf_inst_pkg::EW_WORD,
              vrf_inst_pkg::EW_WORD, 0, 1'b0, waddr0, '0);
        check_bit("ready_for_load_o", 1'b0, ready_for_load_o);
        fires = 0;
        while (fires < n_fire) begin
            gap = int'($urandom_range(0, 3));
            for (int g = 0; g <= gap; g++) begin
                @(negedge clk_i);
                bwen_v       = $urandom;
                load_bwen_i  = bwen_v;
                load_valid_i = (g == gap);
                load_last_i  = (g == gap) && (fires == n_fire - 1);
                #SAMPLE_DLY;
                check_bit("ready_o", 1'b0, ready_o);
                check_bit("ready_for_load_o", 1'b1, ready_for_load_o);
                check_bwen("vrf_bwen_o", (g == gap) ? bwen_v : '0, vrf_bwen_o);
                check_waddr(waddr0 + AW'(fires));
            end
            fires++;
        end
        @(negedge clk_i);
        load_valid_i = 1'b0;
        load_last_i  = 1'b0;
        load_bwen_i  = '0;
        #SAMPLE_DLY;
        check_bit("ready_o", 1'b1, ready_o);
        check_bit("ready_for_load_o", 1'b0, ready_for_load_o);
        check_waddr(waddr0 + AW'(n_fire));
    endtask

    task automatic mask_clear_test();
        run_normal(VLW'($urandom_range(9, 64)), vrf_inst_pkg::EW_HALF,
                   vrf_inst_pkg::EW_HALF, int'($urandom_range(1, 8)), 1'b0);
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        void'($urandom(SEED));
        clk_i             = 1'b0;
        rst_i             = 1'b0;
        start_i           = 1'b0;
        inst_kind_i       = vrf_inst_pkg::INST_NORMAL;
        vl_i              = '0;
        vsew_i            = vrf_inst_pkg::EW_NONE;
        wdata_width_i     = vrf_inst_pkg::EW_NONE;
        inst_delay_i      = '0;
        vector_mask_i     = 1'b0;
        vrf_start_waddr_i = '0;
        vrf_start_raddr_i = '0;
        load_valid_i      = 1'b0;
        load_last_i       = 1'b0;
        load_bwen_i       = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b1;

        reset_test();
        byte_write_test();
        partial_row_test();
        store_test();
        load_test();
        mask_clear_test();

        $display("all tests passed");
        $finish;
    end

endmodule

// File: rtl/byte_enable_gen.sv
// Byte write enable generator
// Rotating pattern for sub-word writes, load enables passed per lane

`timescale 1ns/1ps

`include "vrf_ctrl_settings.svh"

module byte_enable_gen (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            wr_en_i,
    input  vrf_inst_pkg::elem_width_e       width_i,
    input  logic                            load_mode_i,
    input  logic                            load_fire_i,
    input  logic [`VLANE_NUM-1:0][3:0]      load_bwen_i,
    output logic [`VLANE_NUM-1:0][3:0]      bwen_o,
    output logic                            wr_step_o
);

    logic [3:0] rot4_q;     // One-hot byte
    logic [1:0] rot2_q;     // Halfword pair select
    logic       pat_en;
    logic [3:0] pattern;
    logic       last_lane;

    assign pat_en = wr_en_i & ~load_mode_i;

    // Rotate while writing, restart otherwise
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rot4_q <= 4'b0001;
            rot2_q <= 2'b01;
        end else if (pat_en) begin
            rot4_q <= {rot4_q[2:0], rot4_q[3]};
            rot2_q <= {rot2_q[0], rot2_q[1]};
        end else begin
            rot4_q <= 4'b0001;
            rot2_q <= 2'b01;
        end
    end

    always_comb begin
        pattern   = 4'b0000;
        last_lane = 1'b0;
        if (pat_en) begin
            case (width_i)
                vrf_inst_pkg::EW_BYTE: begin
                    pattern   = rot4_q;
                    last_lane = rot4_q[3];
                end
                vrf_inst_pkg::EW_HALF: begin
                    pattern   = {{2{rot2_q[1]}}, {2{rot2_q[0]}}};
                    last_lane = rot2_q[1];
                end
                vrf_inst_pkg::EW_WORD: begin
                    pattern   = 4'b1111;
                    last_lane = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < `VLANE_NUM; i++) begin
            if (load_mode_i) begin
                bwen_o[i] = load_fire_i ? load_bwen_i[i] : 4'b0000;
            end else begin
                bwen_o[i] = pattern;
            end
        end
    end

    // Word done, write address may advance
    assign wr_step_o = load_mode_i ? load_fire_i : last_lane;

endmodule

// File: rtl/lane_valid_mask.sv
// Per-lane read data valid mask
// Tracks the elements left and marks the lanes holding them, row by row

`timescale 1ns/1ps

`include "vrf_ctrl_settings.svh"

module lane_valid_mask (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [`VL_W-1:0]       vl_i,
    input  logic                   load_i,
    input  logic                   shift_i,
    output logic [`VLANE_NUM-1:0]  valid_o
);

    localparam int VW = `VL_W;
    localparam logic [VW-1:0] LANES = VW'(`VLANE_NUM);

    logic [VW-1:0]         remain_q;    // Elements not yet covered
    logic [`VLANE_NUM-1:0] row_valid;

    always_comb begin
        for (int i = 0; i < `VLANE_NUM; i++) begin
            row_valid[i] = (remain_q > VW'(i));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            remain_q <= '0;
            valid_o  <= '0;
        end else begin
            if (load_i) begin
                remain_q <= vl_i;
            end else if (shift_i) begin
                remain_q <= (remain_q > LANES) ? remain_q - LANES : '0;
            end
            valid_o <= shift_i ? row_valid : '0;    // Partial last row
        end
    end

endmodule

// File: rtl/vrf_access_ctrl.sv
// VRF access controller top
// Sequencer, address counters, byte enables and read valid mask
// for an eight-lane vector register file

`timescale 1ns/1ps

`include "vrf_ctrl_settings.svh"

module vrf_access_ctrl (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    input  logic                                        start_i,
    input  vrf_inst_pkg::inst_kind_e                    inst_kind_i,
    input  logic [`VL_W-1:0]                            vl_i,
    input  vrf_inst_pkg::elem_width_e                   vsew_i,
    input  vrf_inst_pkg::elem_width_e                   wdata_width_i,
    input  logic [`VPL_W-1:0]                           inst_delay_i,
    input  logic                                        vector_mask_i,
    input  logic [`VRF_ADDR_W-1:0]                      vrf_start_waddr_i,
    input  logic [`RD_PORT_NUM-1:0][`VRF_ADDR_W-1:0]    vrf_start_raddr_i,
    input  logic                                        load_valid_i,
    input  logic                                        load_last_i,
    input  logic [`VLANE_NUM-1:0][3:0]                  load_bwen_i,
    output logic                                        ready_o,
    output logic                                        ready_for_load_o,
    output logic                                        store_data_valid_o,
    output logic [`RD_PORT_NUM-1:0][`VRF_ADDR_W-1:0]    vrf_raddr_o,
    output logic [`VLANE_NUM-1:0][`VRF_ADDR_W-1:0]      vrf_waddr_o,
    output logic [`VLANE_NUM-1:0][3:0]                  vrf_bwen_o,
    output logic [`VLANE_NUM-1:0]                       read_data_valid_o,
    output logic [`VPL_W-1:0]                           vmrf_addr_o,
    output logic                                        vmrf_wen_o
);

    logic                      addr_load;
    logic                      rd_step;
    logic                      wr_en;
    logic                      wr_step;
    logic                      mask_load;
    logic                      mask_shift;
    vrf_inst_pkg::elem_width_e wr_width;
    vrf_inst_pkg::elem_width_e rd_width;
    logic [`VRF_ADDR_W-1:0]    waddr;

    vrf_seq_fsm i_seq (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i), .inst_kind_i(inst_kind_i),
        .vl_i(vl_i), .vsew_i(vsew_i), .wdata_width_i(wdata_width_i),
        .inst_delay_i(inst_delay_i), .vector_mask_i(vector_mask_i),
        .load_valid_i(load_valid_i), .load_last_i(load_last_i),
        .ready_o(ready_o), .ready_for_load_o(ready_for_load_o),
        .store_data_valid_o(store_data_valid_o), .addr_load_o(addr_load),
        .rd_step_o(rd_step), .wr_en_o(wr_en), .wr_width_o(wr_width),
        .rd_width_o(rd_width), .mask_load_o(mask_load), .mask_shift_o(mask_shift),
        .vmrf_addr_o(vmrf_addr_o), .vmrf_wen_o(vmrf_wen_o)
    );

    ////////////////////////////////////////
    // Address counters
    vrf_addr_counter i_waddr_cnt (        // Steps one word per write step
        .clk_i(clk_i), .rst_i(rst_i), .start_addr_i(vrf_start_waddr_i),
        .load_i(addr_load), .en_i(wr_step), .width_i(vrf_inst_pkg::EW_WORD),
        .addr_o(waddr)
    );

    for (genvar p = 0; p < `RD_PORT_NUM; p++) begin : g_raddr
        vrf_addr_counter i_raddr_cnt (
            .clk_i(clk_i), .rst_i(rst_i), .start_addr_i(vrf_start_raddr_i[p]),
            .load_i(addr_load), .en_i(rd_step), .width_i(rd_width),
            .addr_o(vrf_raddr_o[p])
        );
    end

    assign vrf_waddr_o = {`VLANE_NUM{waddr}};    // Same row in every lane

    ////////////////////////////////////////
    // Write enables and read valid
    byte_enable_gen i_bwen (
        .clk_i(clk_i), .rst_i(rst_i), .wr_en_i(wr_en), .width_i(wr_width),
        .load_mode_i(ready_for_load_o), .load_fire_i(load_valid_i),
        .load_bwen_i(load_bwen_i), .bwen_o(vrf_bwen_o), .wr_step_o(wr_step)
    );

    lane_valid_mask i_valid (
        .clk_i(clk_i), .rst_i(rst_i), .vl_i(vl_i), .load_i(mask_load),
        .shift_i(mask_shift), .valid_o(read_data_valid_o)
    );

endmodule

// File: rtl/vrf_addr_counter.sv
// VRF address counter
// Word address with a byte position inside the word, advanced by
// the element size and carried into the word address on wrap

`timescale 1ns/1ps

`include "vrf_ctrl_settings.svh"

module vrf_addr_counter (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [`VRF_ADDR_W-1:0]    start_addr_i,
    input  logic                      load_i,
    input  logic                      en_i,
    input  vrf_inst_pkg::elem_width_e width_i,
    output logic [`VRF_ADDR_W-1:0]    addr_o
);

    localparam int AW = `VRF_ADDR_W;

    logic [AW-1:0] addr_q;
    logic [1:0]    pos_q;       // Byte position in the word
    logic [2:0]    step;
    logic [2:0]    pos_sum;

    // Bytes per element
    always_comb begin
        case (width_i)
            vrf_inst_pkg::EW_BYTE: step = 3'd1;
            vrf_inst_pkg::EW_HALF: step = 3'd2;
            vrf_inst_pkg::EW_WORD: step = 3'd4;
            default:               step = 3'd0;
        endcase
    end

    assign pos_sum = {1'b0, pos_q} + step;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q <= '0;
            pos_q  <= '0;
        end else if (load_i) begin
            addr_q <= start_addr_i;
            pos_q  <= '0;
        end else if (en_i) begin
            pos_q  <= pos_sum[1:0];
            addr_q <= addr_q + AW'(pos_sum[2]);    // Carry out of the word
        end
    end

    assign addr_o = addr_q;

endmodule

// File: rtl/vrf_ctrl_settings.svh
// VRF access controller settings
// Lane count, memory depth and element limits shared by the RTL

`ifndef VRF_CTRL_SETTINGS_SVH
`define VRF_CTRL_SETTINGS_SVH

// Number of vector lanes, power of two
`define VLANE_NUM 8

// Words per lane memory
`define MEM_DEPTH 512

// Most elements a single lane can hold
`define MAX_VL_PER_LANE 256

// Operand read address ports
`define RD_PORT_NUM 3

// Derived widths
`define VRF_ADDR_W ($clog2(`MEM_DEPTH))
`define VPL_W ($clog2(`MAX_VL_PER_LANE))
`define VL_W ($clog2(`VLANE_NUM * `MAX_VL_PER_LANE))

`endif

// File: rtl/vrf_inst_pkg.sv
// Instruction interface types for the VRF access controller
// Instruction kind and element width encodings

package vrf_inst_pkg;

    ////////////////////////////////////////
    // Instruction kind
    // Encodings not listed here are illegal
    typedef enum logic [2:0] {
        INST_NORMAL = 3'd0,    // Arithmetic with write back
        INST_STORE  = 3'd2,    // Unit-stride store
        INST_LOAD   = 3'd4     // Unit-stride load
    } inst_kind_e;

    ////////////////////////////////////////
    // Element width
    // Zero disables writes
    typedef enum logic [1:0] {
        EW_NONE = 2'd0,
        EW_BYTE = 2'd1,        // Four elements per word
        EW_HALF = 2'd2,        // Two elements per word
        EW_WORD = 2'd3
    } elem_width_e;

endpackage

// File: rtl/vrf_seq_fsm.sv
// Instruction sequencer for the VRF access controller
// Latches one instruction, runs the read and write phases and
// counts mask register writes

`timescale 1ns/1ps

`include "vrf_ctrl_settings.svh"

module vrf_seq_fsm (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          start_i,
    input  vrf_inst_pkg::inst_kind_e      inst_kind_i,
    input  logic [`VL_W-1:0]              vl_i,
    input  vrf_inst_pkg::elem_width_e     vsew_i,
    input  vrf_inst_pkg::elem_width_e     wdata_width_i,
    input  logic [`VPL_W-1:0]             inst_delay_i,
    input  logic                          vector_mask_i,
    input  logic                          load_valid_i,
    input  logic                          load_last_i,
    output logic                          ready_o,
    output logic                          ready_for_load_o,
    output logic                          store_data_valid_o,
    output logic                          addr_load_o,
    output logic                          rd_step_o,
    output logic                          wr_en_o,
    output vrf_inst_pkg::elem_width_e     wr_width_o,
    output vrf_inst_pkg::elem_width_e     rd_width_o,
    output logic                          mask_load_o,
    output logic                          mask_shift_o,
    output logic [`VPL_W-1:0]             vmrf_addr_o,
    output logic                          vmrf_wen_o
);

    localparam int CNT_W   = `VPL_W + 1;            // Holds delay plus read limit
    localparam int SUM_W   = CNT_W + 1;
    localparam int LANE_SH = $clog2(`VLANE_NUM);

    vrf_seq_pkg::seq_state_e state_q, state_d;
    logic                    ready_q;
    logic                    load_armed_q;
    logic [CNT_W-1:0]        main_cnt_q;
    logic [`VPL_W-1:0]       vmrf_cnt_q;

    // Latched instruction
    logic [`VPL_W-1:0]           inst_delay_q;
    logic [CNT_W-1:0]            read_limit_q;
    vrf_inst_pkg::elem_width_e   vsew_q;
    vrf_inst_pkg::elem_width_e   wdata_width_q;
    logic                        vector_mask_q;

    logic             accept;
    logic [CNT_W-1:0] read_limit_d;
    logic [SUM_W-1:0] cnt_ext;
    logic [SUM_W-1:0] cnt_nxt;
    logic [SUM_W-1:0] delay_ext;
    logic [SUM_W-1:0] limit_ext;
    logic [SUM_W-1:0] write_end;
    logic             in_read;
    logic             in_write;
    logic             reading;
    logic             normal_wr;

    assign accept = start_i & ready_q;

    // Rows per lane, rounded up
    assign read_limit_d = CNT_W'(vl_i >> LANE_SH) + CNT_W'(vl_i[LANE_SH-1:0] != '0);

    ////////////////////////////////////////
    // Phase windows
    assign cnt_ext   = SUM_W'(main_cnt_q);
    assign cnt_nxt   = cnt_ext + SUM_W'(1);
    assign delay_ext = SUM_W'(inst_delay_q);
    assign limit_ext = SUM_W'(read_limit_q);
    assign write_end = delay_ext + limit_ext;

    assign in_read  = (cnt_ext < limit_ext);
    assign in_write = (cnt_ext >= delay_ext) && (cnt_ext < write_end);

    assign reading   = ((state_q == vrf_seq_pkg::SEQ_NORMAL) ||
                        (state_q == vrf_seq_pkg::SEQ_READ)) && in_read;
    assign normal_wr = (state_q == vrf_seq_pkg::SEQ_NORMAL) && in_write;

    ////////////////////////////////////////
    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            vrf_seq_pkg::SEQ_IDLE: begin
                if (accept) begin
                    case (inst_kind_i)
                        vrf_inst_pkg::INST_NORMAL: state_d = vrf_seq_pkg::SEQ_NORMAL;
                        vrf_inst_pkg::INST_STORE:  state_d = vrf_seq_pkg::SEQ_READ;
                        vrf_inst_pkg::INST_LOAD:   state_d = vrf_seq_pkg::SEQ_LOAD;
                        default:                   state_d = vrf_seq_pkg::SEQ_IDLE;
                    endcase
                end
            end
            vrf_seq_pkg::SEQ_NORMAL: begin
                if (cnt_nxt >= write_end) begin    // Last write back row
                    state_d = vrf_seq_pkg::SEQ_IDLE;
                end
            end
            vrf_seq_pkg::SEQ_READ: begin
                if (cnt_nxt >= limit_ext) begin
                    state_d = vrf_seq_pkg::SEQ_IDLE;
                end
            end
            vrf_seq_pkg::SEQ_LOAD: begin
                if (load_last_i) begin
                    state_d = vrf_seq_pkg::SEQ_IDLE;
                end
            end
            default: state_d = vrf_seq_pkg::SEQ_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // Control registers
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q      <= vrf_seq_pkg::SEQ_IDLE;
            ready_q      <= 1'b1;
            load_armed_q <= 1'b0;
            main_cnt_q   <= '0;
            vmrf_cnt_q   <= '0;
        end else begin
            state_q <= state_d;

            if (accept) begin
                ready_q <= 1'b0;
            end else if (!ready_q && (state_d == vrf_seq_pkg::SEQ_IDLE)) begin
                ready_q <= 1'b1;
            end

            // Load data is taken from the second load cycle on
            load_armed_q <= (state_q == vrf_seq_pkg::SEQ_LOAD) &&
                            (state_d == vrf_seq_pkg::SEQ_LOAD);

            if (accept) begin
                main_cnt_q <= '0;
            end else if ((state_q == vrf_seq_pkg::SEQ_NORMAL) ||
                         (state_q == vrf_seq_pkg::SEQ_READ)) begin
                main_cnt_q <= main_cnt_q + CNT_W'(1);
            end

            if (accept) begin
                vmrf_cnt_q <= '0;
            end else if (normal_wr) begin
                vmrf_cnt_q <= vmrf_cnt_q + `VPL_W'(1);    // One mask row per write
            end
        end
    end

    // Instruction fields
    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_delay_q  <= inst_delay_i;
            read_limit_q  <= read_limit_d;
            vsew_q        <= vsew_i;
            wdata_width_q <= wdata_width_i;
            vector_mask_q <= vector_mask_i;
        end
    end

    ////////////////////////////////////////
    // Outputs
    assign ready_o            = ready_q;
    assign ready_for_load_o   = load_armed_q;
    assign store_data_valid_o = (state_q == vrf_seq_pkg::SEQ_READ) && in_read;
    assign addr_load_o        = accept;
    assign rd_step_o          = reading;
    assign wr_en_o            = normal_wr | (load_armed_q & load_valid_i);
    assign wr_width_o         = wdata_width_q;
    assign rd_width_o         = vsew_q;
    assign mask_load_o        = accept;
    assign mask_shift_o       = reading;    // Valid mask follows the reads
    assign vmrf_addr_o        = vmrf_cnt_q;
    assign vmrf_wen_o         = normal_wr & vector_mask_q;

endmodule

// File: rtl/vrf_seq_pkg.sv
// Internal sequencing types for the VRF access controller

package vrf_seq_pkg;

    // Sequencer state
    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,     // Waiting for start
        SEQ_NORMAL = 2'd1,     // Read then delayed write back
        SEQ_READ   = 2'd2,     // Read only, used by stores
        SEQ_LOAD   = 2'd3      // Write of incoming load data
    } seq_state_e;

endpackage

// File: run.sh
#!/bin/sh
# Compile and run the VRF access controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f \
    --top-module vrf_access_ctrl_tb -o vrf_access_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/vrf_access_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
